// ==== bench/exu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_checker import rv_isa_pkg::*, rv_csr_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         prev_valid_i,
  input  wire         ready_i,
  input  wire         next_ready_i,
  input  wire         valid_i,
  input  wire  [31:0] inst_i,
  input  wire  [31:0] pc_i,
  input  wire  [31:0] op1_i,
  input  wire  [31:0] op2_i,
  input  wire  [31:0] opj_i,
  input  wire  [31:0] imm_i,
  input  var alu_op_t alu_op_i,
  input  wire  [3:0]  rd_i,
  input  wire         ren_i,
  input  wire         system_i,
  input  wire         mem_avalid_i,
  input  wire  [31:0] mem_addr_i,
  input  wire  [31:0] mem_wdata_i,
  input  wire         mem_rvalid_i,
  input  wire         mem_wready_i,
  input  wire  [3:0]  ret_rd_i,
  input  wire  [31:0] ret_wdata_i,
  input  wire  [31:0] ret_npc_i,
  input  wire         ret_redirect_i,
  input  wire  [31:0] ret_pc_i,
  output int          checked_o,
  output int          errors_o
);

  typedef struct packed {
    logic [31:0] inst, pc, op1, op2, opj, imm;
    alu_op_t     alu_op;
    logic [3:0]  rd;
    logic        ren, system;
  } instr_t;

  typedef struct packed {
    logic [31:0] wdata, npc;
    logic        redirect;
  } exp_t;

  instr_t      q[$];
  instr_t      t;
  instr_t      cur;
  exp_t        e;
  logic        hold;
  logic [100:0] saved;
  logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause;

  function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] b, alu_op_t op);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return {31'd0, $signed(a) < $signed(b)};
      alu_sltu: return {31'd0, a < b};
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_or:   return a | b;
      alu_and:  return a & b;
      alu_sle:  return {31'd0, $signed(a) <= $signed(b)};
      alu_sleu: return {31'd0, a <= b};
      default:  return 32'd0;
    endcase
  endfunction

  // sub is beq, xor is bne
  function automatic logic branch_ref(logic [31:0] a, logic [31:0] b, alu_op_t op);
    case (op)
      alu_sub:  return a == b;
      alu_xor:  return a != b;
      alu_slt:  return $signed(a) < $signed(b);
      alu_sltu: return a < b;
      alu_sle:  return $signed(a) <= $signed(b);
      alu_sleu: return a <= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] csr_read(logic [11:0] a);
    case (a)
      csr_mstatus: return m_mstatus;
      csr_mtvec:   return m_mtvec;
      csr_mepc:    return m_mepc;
      csr_mcause:  return m_mcause;
      default:     return 32'd0;
    endcase
  endfunction

  function automatic exp_t predict(instr_t i);
    exp_t        r;
    logic [2:0]  f3;
    logic [11:0] a;
    f3 = i.inst[14:12];
    a = i.inst[31:20];
    r.npc = i.opj + i.imm;
    r.redirect = 1'b0;
    if (i.system && f3 == f3_priv) begin
      r.redirect = 1'b1;
      r.npc = (a == sys_mret) ? m_mepc : m_mtvec;
      r.wdata = csr_read((a == sys_mret) ? csr_mstatus : csr_mcause);
    end else if (i.system) begin
      r.wdata = csr_read(a);
    end else if (i.ren) begin
      r.wdata = (i.op1 + i.imm) ^ 32'h5a5a5a5a;
    end else begin
      r.wdata = alu_ref(i.op1, i.op2, i.alu_op);
      if (i.inst[6:0] == op_jal || i.inst[6:0] == op_jalr) r.redirect = 1'b1;
      else if (i.inst[6:0] == op_branch) r.redirect = branch_ref(i.op1, i.op2, i.alu_op);
    end
    if (i.rd == 4'd0) r.wdata = 32'd0;
    return r;
  endfunction

  task automatic commit_csr(instr_t i);
    logic [2:0]  f3;
    logic [11:0] a;
    logic [31:0] nv;
    f3 = i.inst[14:12];
    a = i.inst[31:20];
    if (i.system && f3 == f3_priv && a == sys_mret) begin
      // mie takes mpie, mpie set
      m_mstatus[3] = m_mstatus[7];
      m_mstatus[7] = 1'b1;
    end else if (i.system && f3 == f3_priv) begin
      m_mcause = 32'd11;
      m_mepc = i.pc;
    end else if (i.system) begin
      case (f3[1:0])
        2'b01:   nv = i.op1;
        2'b10:   nv = csr_read(a) | i.op1;
        default: nv = csr_read(a) & ~i.op1;
      endcase
      case (a)
        csr_mstatus: m_mstatus = nv;
        csr_mtvec:   m_mtvec = nv;
        csr_mepc:    m_mepc = nv;
        csr_mcause:  m_mcause = nv;
        default: ;
      endcase
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors_o++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      q.delete();
      hold = 1'b0;
      checked_o = 0;
      errors_o = 0;
      {m_mstatus, m_mtvec, m_mepc, m_mcause} = '0;
    end else begin
      if (hold && valid_i &&
          saved !== {ret_rd_i, ret_wdata_i, ret_npc_i, ret_redirect_i, ret_pc_i}) begin
        $display("outputs changed while next_ready_i was low");
        errors_o++;
      end
      hold = valid_i && !next_ready_i;
      saved = {ret_rd_i, ret_wdata_i, ret_npc_i, ret_redirect_i, ret_pc_i};
      if (valid_i && next_ready_i) begin
        if (q.size() == 0) begin
          $display("valid_o retired with no accepted instruction left");
          errors_o++;
        end else begin
          t = q.pop_front();
          e = predict(t);
          check_value("rd_o", {28'd0, ret_rd_i}, {28'd0, t.rd});
          check_value("reg_wdata_o", ret_wdata_i, e.wdata);
          check_value("redirect_o", {31'd0, ret_redirect_i}, {31'd0, e.redirect});
          if (e.redirect) check_value("npc_o", ret_npc_i, e.npc);
          check_value("pc_o", ret_pc_i, t.pc);
          commit_csr(t);
          checked_o++;
        end
      end
      if (mem_avalid_i && ready_i) begin
        $display("ready_o was high during a memory access");
        errors_o++;
      end
      if (mem_avalid_i && (mem_rvalid_i || mem_wready_i) && q.size() != 0) begin
        cur = q[q.size()-1];
        check_value("mem_addr_o", mem_addr_i, cur.op1 + cur.imm);
        if (!cur.ren) check_value("mem_wdata_o", mem_wdata_i, cur.op2);
      end
      if (prev_valid_i && ready_i) begin
        q.push_back({inst_i, pc_i, op1_i, op2_i, opj_i, imm_i, alu_op_i, rd_i, ren_i, system_i});
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb import rv_isa_pkg::*, rv_csr_pkg::*; ();

  localparam int n_per_test = 150;
  localparam int n_tests = 6;
  localparam int cycle_limit = n_per_test * n_tests * 12;

  logic        clk, rst, prev_valid_i, next_ready_i;
  logic        ren_i, wen_i, jen_i, system_i, csr_wen_i, mem_rvalid_i, mem_wready_i;
  logic [31:0] inst_i, pc_i, op1_i, op2_i, opj_i, imm_i, mem_rdata_i;
  alu_op_t     alu_op_i;
  logic [3:0]  rd_i;
  wire         ready_o, valid_o, mem_avalid_o, redirect_o;
  wire  [31:0] mem_addr_o, mem_wdata_o, reg_wdata_o, npc_o, pc_o;
  wire  [3:0]  rd_o;
  int          checked, errors, issued, cycles, ready_pct, resp_wait;
  logic        mem_is_load, resp_busy;

  alu_op_t     br_ops [6] = '{alu_sub, alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu};
  logic [2:0]  csr_f3s [6] = '{f3_csrrw, f3_csrrs, f3_csrrc, f3_csrrwi, f3_csrrsi, f3_csrrci};
  logic [11:0] csr_addrs [4] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};

  exu_top dut0 (.*);

  exu_checker chk0 (
    .clk(clk), .rst(rst), .prev_valid_i(prev_valid_i), .ready_i(ready_o),
    .next_ready_i(next_ready_i), .valid_i(valid_o), .inst_i(inst_i), .pc_i(pc_i),
    .op1_i(op1_i), .op2_i(op2_i), .opj_i(opj_i), .imm_i(imm_i), .alu_op_i(alu_op_i),
    .rd_i(rd_i), .ren_i(ren_i), .system_i(system_i), .mem_avalid_i(mem_avalid_o),
    .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o), .mem_rvalid_i(mem_rvalid_i),
    .mem_wready_i(mem_wready_i), .ret_rd_i(rd_o), .ret_wdata_i(reg_wdata_o),
    .ret_npc_i(npc_o), .ret_redirect_i(redirect_o), .ret_pc_i(pc_o),
    .checked_o(checked), .errors_o(errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // kinds: 0 alu, 1 branch, 2 jump, 3 load, 4 store, 5 csr, 6 ecall, 7 mret
  task automatic drive_instr(input int kind);
    logic [2:0]  f3;
    logic [11:0] csr_a;
    logic [6:0]  opc;
    logic [3:0]  rd;
    logic [31:0] a, b, pc;
    a = $urandom;
    b = ($urandom % 4 == 0) ? a : $urandom;
    pc = $urandom & 32'hffff_fffc;
    rd = 4'($urandom);
    f3 = f3_priv;
    csr_a = 12'h000;
    opc = op_reg;
    {ren_i, wen_i, jen_i, system_i, csr_wen_i} <= 5'b0;
    alu_op_i <= alu_op_t'($urandom % 12);
    op1_i <= a;
    op2_i <= b;
    opj_i <= $urandom;
    imm_i <= $urandom;
    case (kind)
      1: begin
        opc = op_branch;
        rd = 4'd0;
        jen_i <= 1'b1;
        alu_op_i <= br_ops[$urandom % 6];
      end
      2: begin
        opc = ($urandom % 2 == 0) ? op_jal : op_jalr;
        jen_i <= 1'b1;
        op1_i <= pc;
        op2_i <= 32'd4;
        alu_op_i <= alu_add;
        if (opc == op_jal) opj_i <= pc;
      end
      3: begin
        opc = op_load;
        ren_i <= 1'b1;
      end
      4: begin
        opc = op_store;
        rd = 4'd0;
        wen_i <= 1'b1;
      end
      5: begin
        opc = op_system;
        f3 = csr_f3s[$urandom % 6];
        csr_a = csr_addrs[$urandom % 4];
        {system_i, csr_wen_i} <= 2'b11;
        // zimm forms carry the 5-bit immediate in op1
        if (f3[2]) op1_i <= a & 32'h1f;
      end
      6, 7: begin
        opc = op_system;
        rd = 4'd0;
        csr_a = (kind == 7) ? sys_mret : sys_ecall;
        system_i <= 1'b1;
      end
      default: ;
    endcase
    inst_i <= {csr_a, 5'd0, f3, 1'b0, rd, opc};
    rd_i <= rd;
    pc_i <= pc;
    prev_valid_i <= 1'b1;
    do @(posedge clk); while (!ready_o);
    mem_is_load <= (kind == 3);
    issued++;
  endtask

  task automatic run_test(input string name, input int lo, input int hi, input int pct);
    int err0;
    err0 = errors;
    ready_pct = pct;
    repeat (n_per_test) drive_instr(lo + int'($urandom % (hi - lo + 1)));
    prev_valid_i <= 1'b0;
    while (checked != issued) @(posedge clk);
    $display("test %s: %0d checked so far, %0d errors", name, checked, errors - err0);
  endtask

  always @(posedge clk) begin
    next_ready_i <= !rst && (int'($urandom % 100) < ready_pct);
  end

  // single-cycle response 0 to 5 cycles after avalid rises
  always @(posedge clk) begin
    mem_rvalid_i <= 1'b0;
    mem_wready_i <= 1'b0;
    if (mem_avalid_o && !mem_rvalid_i && !mem_wready_i) begin
      if (!resp_busy) begin
        resp_busy = 1'b1;
        resp_wait = $urandom % 6;
      end
      if (resp_wait == 0) begin
        resp_busy = 1'b0;
        if (mem_is_load) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i <= mem_addr_o ^ 32'h5a5a5a5a;
        end else begin
          mem_wready_i <= 1'b1;
        end
      end else begin
        resp_wait--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d checked", cycles, checked, issued);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc99648b9));
    rst <= 1'b1;
    {prev_valid_i, next_ready_i, ren_i, wen_i, jen_i} <= 5'b0;
    {system_i, csr_wen_i, mem_rvalid_i, mem_wready_i, mem_is_load} <= 5'b0;
    {inst_i, pc_i, op1_i, op2_i, opj_i, imm_i, mem_rdata_i} <= '0;
    alu_op_i <= alu_add;
    rd_i <= 4'd0;
    resp_busy = 1'b0;
    ready_pct = 70;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    run_test("alu", 0, 0, 70);
    run_test("branch_jump", 1, 2, 70);
    run_test("load_store", 3, 4, 60);
    run_test("csr", 5, 5, 70);
    run_test("ecall_mret", 5, 7, 70);
    run_test("backpressure", 0, 7, 25);
    $display("summary: %0d issued, %0d checked, %0d errors", issued, checked, errors);
    if (errors == 0 && checked == issued) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/rv_isa_pkg.sv
hdl/rv_csr_pkg.sv
hdl/idu_pipe_if.sv
hdl/csr_port_if.sv
hdl/exu_alu.sv
hdl/exu_csr.sv
hdl/exu.sv
hdl/exu_top.sv
bench/exu_checker.sv
bench/exu_tb.sv

// ==== hdl/csr_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_port_if import rv_isa_pkg::*; import rv_csr_pkg::*; ();
  logic                  wen;
  logic                  commit;
  logic                  ecall;
  logic [csr_addr_w-1:0] waddr;
  logic [xlen_w-1:0]     wdata;
  logic [csr_addr_w-1:0] waddr2;
  logic [xlen_w-1:0]     wdata2;
  logic [xlen_w-1:0]     rdata;
  logic [xlen_w-1:0]     mepc;
  logic [xlen_w-1:0]     mtvec;

  modport exu_side (
    output wen, commit, ecall, waddr, wdata, waddr2, wdata2,
    input  rdata, mepc, mtvec
  );
  modport csr_side (
    input  wen, commit, ecall, waddr, wdata, waddr2, wdata2,
    output rdata, mepc, mtvec
  );
endinterface

`default_nettype wire

// ==== hdl/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu import rv_isa_pkg::*; import rv_csr_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  idu_pipe_if.consumer      idu,
  csr_port_if.exu_side      csr,
  output logic              mem_avalid_o,
  output logic [xlen_w-1:0] mem_addr_o,
  output logic [xlen_w-1:0] mem_wdata_o,
  input  wire  [xlen_w-1:0] mem_rdata_i,
  input  wire               mem_rvalid_i,
  input  wire               mem_wready_i,
  input  wire               prev_valid_i,
  input  wire               next_ready_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic [3:0]        rd_o,
  output logic [xlen_w-1:0] reg_wdata_o,
  output logic [xlen_w-1:0] npc_o,
  output logic              redirect_o,
  output logic [xlen_w-1:0] pc_o
);

  logic [31:0]       inst_q;
  logic [xlen_w-1:0] op1_q, op2_q, tgt_q, ld_data_q, alu_res, csr_wdata;
  alu_op_t           alu_op_q;
  logic              ren_q, wen_q, system_q, csr_wen_q;
  logic              accept, mem_resp, is_priv, is_ecall, is_mret, br_taken, take;
  logic [2:0]        funct3;
  mstatus_u          mst_old, mst_new;

  assign accept   = prev_valid_i & ready_o;
  assign mem_resp = (ren_q & mem_rvalid_i) | (wen_q & mem_wready_i);
  // hold while a result waits or an access is outstanding
  assign ready_o  = !mem_avalid_o & (!valid_o | next_ready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o      <= 1'b0;
      mem_avalid_o <= 1'b0;
    end else begin
      if (accept) begin
        valid_o      <= !(idu.ren | idu.wen);
        mem_avalid_o <= idu.ren | idu.wen;
      end else if (next_ready_i) begin
        valid_o <= 1'b0;
      end
      if (mem_avalid_o & mem_resp) begin
        mem_avalid_o <= 1'b0;
        valid_o      <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q    <= idu.inst;
      pc_o      <= idu.pc;
      op1_q     <= idu.op1;
      op2_q     <= idu.op2;
      alu_op_q  <= idu.alu_op;
      rd_o      <= idu.rd;
      ren_q     <= idu.ren;
      wen_q     <= idu.wen;
      system_q  <= idu.system;
      csr_wen_q <= idu.csr_wen;
      if (idu.jen) tgt_q <= idu.opj + idu.imm;
      if (idu.ren | idu.wen) mem_addr_o <= idu.op1 + idu.imm;
    end
    if (mem_avalid_o & ren_q & mem_rvalid_i) ld_data_q <= mem_rdata_i;
  end

  assign mem_wdata_o = op2_q;

  exu_alu u_alu (.src1_i(op1_q), .src2_i(op2_q), .op_i(alu_op_q), .res_o(alu_res));

  assign funct3   = inst_q[14:12];
  assign is_priv  = system_q & (funct3 == f3_priv);
  assign is_ecall = is_priv & (inst_q[31:20] == sys_ecall);
  assign is_mret  = is_priv & (inst_q[31:20] == sys_mret);

  // csr steering, ecall writes mcause and mepc together
  assign csr.waddr  = is_ecall ? csr_mcause : (is_mret ? csr_mstatus : inst_q[31:20]);
  assign csr.waddr2 = csr_mepc;
  assign csr.wdata2 = pc_o;
  assign csr.ecall  = is_ecall;
  assign csr.wen    = system_q & (csr_wen_q | is_ecall | is_mret);
  assign csr.commit = valid_o & next_ready_i;
  assign csr.wdata  = csr_wdata;

  always_comb begin
    mst_old.word   = csr.rdata;
    mst_new        = mst_old;
    mst_new.f.mie  = mst_old.f.mpie;
    mst_new.f.mpie = 1'b1;
    case (funct3)
      f3_csrrw, f3_csrrwi: csr_wdata = op1_q;
      f3_csrrs, f3_csrrsi: csr_wdata = csr.rdata | op1_q;
      f3_csrrc, f3_csrrci: csr_wdata = csr.rdata & ~op1_q;
      default:             csr_wdata = is_ecall ? cause_ecall_m : mst_new.word;
    endcase
  end

  assign reg_wdata_o = (rd_o == 4'd0) ? '0 : (ren_q ? ld_data_q : (system_q ? csr.rdata : alu_res));

  always_comb begin
    case (alu_op_q)
      alu_sub:                                    br_taken = ~|alu_res;
      alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu: br_taken = |alu_res;
      default:                                    br_taken = 1'b0;
    endcase
  end

  always_comb begin
    npc_o = tgt_q;
    take  = 1'b0;
    case (inst_q[6:0])
      op_jal, op_jalr: take = 1'b1;
      op_branch:       take = br_taken;
      op_system: begin
        take = is_ecall | is_mret;
        if (is_ecall) npc_o = csr.mtvec;
        else if (is_mret) npc_o = csr.mepc;
      end
      default: ;
    endcase
  end

  assign redirect_o = take & valid_o;

endmodule

`default_nettype wire

// ==== hdl/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu import rv_isa_pkg::*; (
  input  wire  [xlen_w-1:0] src1_i,
  input  wire  [xlen_w-1:0] src2_i,
  input  var   alu_op_t     op_i,
  output logic [xlen_w-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       le_s;
  logic       le_u;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign le_s  = $signed(src1_i) <= $signed(src2_i);
  assign le_u  = src1_i <= src2_i;

  always_comb begin
    case (op_i)
      alu_add:  res_o = src1_i + src2_i;
      // zero difference means equal, used by beq
      alu_sub:  res_o = src1_i - src2_i;
      alu_sll:  res_o = src1_i << shamt;
      alu_slt:  res_o = {{(xlen_w-1){1'b0}}, lt_s};
      alu_sltu: res_o = {{(xlen_w-1){1'b0}}, lt_u};
      alu_xor:  res_o = src1_i ^ src2_i;
      alu_srl:  res_o = src1_i >> shamt;
      alu_sra:  res_o = $signed(src1_i) >>> shamt;
      alu_or:   res_o = src1_i | src2_i;
      alu_and:  res_o = src1_i & src2_i;
      alu_sle:  res_o = {{(xlen_w-1){1'b0}}, le_s};
      alu_sleu: res_o = {{(xlen_w-1){1'b0}}, le_u};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/exu_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_csr import rv_isa_pkg::*; import rv_csr_pkg::*; (
  input wire           clk,
  input wire           rst,
  csr_port_if.csr_side csr
);

  mstatus_u          mstatus_q;
  logic [xlen_w-1:0] mtvec_q;
  logic [xlen_w-1:0] mepc_q;
  logic [xlen_w-1:0] mcause_q;
  logic              wr_fire;

  // only when the instruction leaves the stage
  assign wr_fire = csr.wen & csr.commit;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (wr_fire) begin
        case (csr.waddr)
          csr_mstatus: mstatus_q.word <= csr.wdata;
          csr_mtvec:   mtvec_q <= csr.wdata;
          csr_mepc:    mepc_q <= csr.wdata;
          csr_mcause:  mcause_q <= csr.wdata;
          default: ;
        endcase
      end
      // ecall side write, second port wins on overlap
      if (wr_fire & csr.ecall) begin
        case (csr.waddr2)
          csr_mepc:   mepc_q <= csr.wdata2;
          csr_mcause: mcause_q <= csr.wdata2;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (csr.waddr)
      csr_mstatus: csr.rdata = mstatus_q.word;
      csr_mtvec:   csr.rdata = mtvec_q;
      csr_mepc:    csr.rdata = mepc_q;
      csr_mcause:  csr.rdata = mcause_q;
      default:     csr.rdata = '0;
    endcase
  end

  assign csr.mepc  = mepc_q;
  assign csr.mtvec = mtvec_q;

endmodule

`default_nettype wire

// ==== hdl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top import rv_isa_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  input  wire               prev_valid_i,
  output logic              ready_o,
  input  wire               next_ready_i,
  output logic              valid_o,
  input  wire  [31:0]       inst_i,
  input  wire  [xlen_w-1:0] pc_i,
  input  wire  [xlen_w-1:0] op1_i,
  input  wire  [xlen_w-1:0] op2_i,
  input  wire  [xlen_w-1:0] opj_i,
  input  wire  [xlen_w-1:0] imm_i,
  input  var   alu_op_t     alu_op_i,
  input  wire  [3:0]        rd_i,
  input  wire               ren_i,
  input  wire               wen_i,
  input  wire               jen_i,
  input  wire               system_i,
  input  wire               csr_wen_i,
  output logic              mem_avalid_o,
  output logic [xlen_w-1:0] mem_addr_o,
  output logic [xlen_w-1:0] mem_wdata_o,
  input  wire  [xlen_w-1:0] mem_rdata_i,
  input  wire               mem_rvalid_i,
  input  wire               mem_wready_i,
  output logic [3:0]        rd_o,
  output logic [xlen_w-1:0] reg_wdata_o,
  output logic [xlen_w-1:0] npc_o,
  output logic              redirect_o,
  output logic [xlen_w-1:0] pc_o
);

  idu_pipe_if idu ();
  csr_port_if csr_bus ();

  assign idu.inst    = inst_i;
  assign idu.pc      = pc_i;
  assign idu.op1     = op1_i;
  assign idu.op2     = op2_i;
  assign idu.opj     = opj_i;
  assign idu.imm     = imm_i;
  assign idu.alu_op  = alu_op_i;
  assign idu.rd      = rd_i;
  assign idu.ren     = ren_i;
  assign idu.wen     = wen_i;
  assign idu.jen     = jen_i;
  assign idu.system  = system_i;
  assign idu.csr_wen = csr_wen_i;

  exu u_exu (
    .clk          (clk),
    .rst          (rst),
    .idu          (idu),
    .csr          (csr_bus),
    .mem_avalid_o (mem_avalid_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .rd_o         (rd_o),
    .reg_wdata_o  (reg_wdata_o),
    .npc_o        (npc_o),
    .redirect_o   (redirect_o),
    .pc_o         (pc_o)
  );

  exu_csr u_csr (
    .clk (clk),
    .rst (rst),
    .csr (csr_bus)
  );

endmodule

`default_nettype wire

// ==== hdl/idu_pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface idu_pipe_if import rv_isa_pkg::*; ();
  logic [31:0]       inst;
  logic [xlen_w-1:0] pc;
  logic [xlen_w-1:0] op1;
  logic [xlen_w-1:0] op2;
  logic [xlen_w-1:0] opj;
  logic [xlen_w-1:0] imm;
  alu_op_t           alu_op;
  logic [3:0]        rd;
  logic              ren;
  logic              wen;
  logic              jen;
  logic              system;
  logic              csr_wen;

  modport producer (
    output inst, pc, op1, op2, opj, imm, alu_op, rd, ren, wen, jen, system, csr_wen
  );
  modport consumer (
    input inst, pc, op1, op2, opj, imm, alu_op, rd, ren, wen, jen, system, csr_wen
  );
endinterface

`default_nettype wire

// ==== hdl/rv_csr_pkg.sv ====
`default_nettype none

package rv_csr_pkg;

  localparam int csr_addr_w = 12;

  localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

  // environment call from M-mode
  localparam logic [31:0] cause_ecall_m = 32'd11;

  // raw word for csr access, fields for the mret update
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [18:0] rsvd_hi;
      logic [1:0]  mpp;
      logic [2:0]  rsvd_mid;
      logic        mpie;
      logic [2:0]  rsvd_lo;
      logic        mie;
      logic [2:0]  rsvd_low;
    } f;
  } mstatus_u;

endpackage

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int xlen_w = 32;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 inside the system opcode
  localparam logic [2:0] f3_priv   = 3'b000;
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  localparam logic [11:0] sys_ecall = 12'h000;
  localparam logic [11:0] sys_mret  = 12'h302;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt,
    alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_sle, alu_sleu
  } alu_op_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module exu_tb -o exu_sim
./obj_dir/exu_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0
